// ==== flist.f ====
mul_pkg.sv
mul_rs.sv
mul_pipe.sv
mul_unit.sv
tb_mul_unit.sv

// ==== mul_pipe.sv ====
// three-stage rv32m multiplier, stalls on a missing cdb grant and drops everything on flush
`timescale 1ns/1ps

module mul_pipe
    import mul_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic        flush,
    input  logic        issue_valid,
    input  issue_t      issue,
    input  logic        cdb_grant,     // result leaves on this edge
    output logic        mul_ready,
    output logic        result_valid,
    output mul_result_t result
);

    typedef struct packed {
        logic [xlen:0]       opa;  // 33 bit, extended per func
        logic [xlen:0]       opb;
        logic [prf_len-1:0]  dest_preg;
        logic [rob_len-1:0]  rob_idx;
        mul_func_t           func;
    } s1_t;

    typedef struct packed {
        logic [33:0]         pp_ll;  // lo x lo
        logic [33:0]         pp_lh;  // lo x hi
        logic [33:0]         pp_hl;  // hi x lo
        logic [33:0]         pp_hh;  // hi x hi
        logic [prf_len-1:0]  dest_preg;
        logic [rob_len-1:0]  rob_idx;
        mul_func_t           func;
    } s2_t;

    // sign-extend a partial product to the full product width
    function automatic logic [63:0] widen(input logic [33:0] p);
        return {{30{p[33]}}, p};
    endfunction

    logic               stall;
    logic               s1_valid, s2_valid;
    s1_t                s1, s1_next;
    s2_t                s2, s2_next;
    logic               a_signed, b_signed;
    logic signed [16:0] a_lo, a_hi, b_lo, b_hi;
    logic [63:0]        sum;

    assign stall     = result_valid & ~cdb_grant;  // head blocked, whole pipe waits
    assign mul_ready = ~stall;

    //////////////////////////////////////////////////
    // stage 1: extend operands
    //////////////////////////////////////////////////

    assign a_signed = (issue.func == MULH) || (issue.func == MULHSU);
    assign b_signed = (issue.func == MULH);

    always_comb begin
        s1_next.opa       = {a_signed & issue.opa_value[xlen-1], issue.opa_value};
        s1_next.opb       = {b_signed & issue.opb_value[xlen-1], issue.opb_value};
        s1_next.dest_preg = issue.dest_preg;
        s1_next.rob_idx   = issue.rob_idx;
        s1_next.func      = issue.func;
    end

    //////////////////////////////////////////////////
    // stage 2: four 17x17 partial products
    //////////////////////////////////////////////////

    assign a_lo = {1'b0, s1.opa[15:0]};  // low halves always unsigned
    assign b_lo = {1'b0, s1.opb[15:0]};
    assign a_hi = s1.opa[32:16];          // carries the extension bit
    assign b_hi = s1.opb[32:16];

    always_comb begin
        s2_next.pp_ll     = a_lo * b_lo;
        s2_next.pp_lh     = a_lo * b_hi;
        s2_next.pp_hl     = a_hi * b_lo;
        s2_next.pp_hh     = a_hi * b_hi;
        s2_next.dest_preg = s1.dest_preg;
        s2_next.rob_idx   = s1.rob_idx;
        s2_next.func      = s1.func;
    end

    //////////////////////////////////////////////////
    // stage 3: sum and pick the word
    //////////////////////////////////////////////////

    // mod 2^64 is enough, the rv32m product fits
    assign sum = widen(s2.pp_ll) + (widen(s2.pp_lh) << 16) + (widen(s2.pp_hl) << 16)
               + (widen(s2.pp_hh) << 32);

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid     <= issue_valid;
            s2_valid     <= s1_valid;
            result_valid <= s2_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            s1               <= s1_next;
            s2               <= s2_next;
            result.dest_preg <= s2.dest_preg;
            result.rob_idx   <= s2.rob_idx;
            result.value     <= (s2.func == MUL) ? sum[31:0] : sum[63:32];
        end
    end

    // a waiting result must not change under the bus
    a_result_hold: assert property (
        @(posedge clock) disable iff (rst || flush)
        result_valid && !cdb_grant |=> result_valid && $stable(result));

endmodule

// ==== mul_pkg.sv ====
// shared widths, function codes and packets for the multiply path; compile before the rest

package mul_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int xlen    = 32;  // data path width
    localparam int prf_len = 6;   // physical register tag width
    localparam int rob_len = 5;   // reorder buffer index width

    // multiply flavour, rv32m funct3 order
    typedef enum logic [1:0] {
        MUL    = 2'd0,  // low word, sign does not matter
        MULH   = 2'd1,  // high word, signed x signed
        MULHSU = 2'd2,  // high word, signed x unsigned
        MULHU  = 2'd3   // high word, unsigned x unsigned
    } mul_func_t;

    //////////////////////////////////////////////////
    // operand slot, read as tag or value by its ready bit
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [xlen-prf_len-1:0] pad;  // kept zero while waiting
        logic [prf_len-1:0]      tag;  // producer's physical register
    } operand_tag_t;

    typedef union packed {
        logic [xlen-1:0] value;     // ready view
        operand_tag_t    tag_view;  // pending view
    } operand_t;

    // one station slot
    typedef struct packed {
        logic                opa_ready;
        operand_t            opa;
        logic                opb_ready;
        operand_t            opb;
        logic [prf_len-1:0]  dest_preg;
        logic [rob_len-1:0]  rob_idx;
        mul_func_t           func;
    } rs_entry_t;

    // what dispatch hands over, tag and value side by side
    typedef struct packed {
        logic                opa_ready;
        logic [xlen-1:0]     opa_value;
        logic [prf_len-1:0]  opa_tag;
        logic                opb_ready;
        logic [xlen-1:0]     opb_value;
        logic [prf_len-1:0]  opb_tag;
        logic [prf_len-1:0]  dest_preg;
        logic [rob_len-1:0]  rob_idx;
        mul_func_t           func;
    } dispatch_t;

    // station to multiplier, both operands resolved
    typedef struct packed {
        logic [xlen-1:0]     opa_value;
        logic [xlen-1:0]     opb_value;
        logic [prf_len-1:0]  dest_preg;
        logic [rob_len-1:0]  rob_idx;
        mul_func_t           func;
    } issue_t;

    // common data bus broadcast
    typedef struct packed {
        logic                valid;
        logic [prf_len-1:0]  tag;
        logic [xlen-1:0]     value;
    } cdb_t;

    // multiplier result waiting for a bus grant
    typedef struct packed {
        logic [prf_len-1:0]  dest_preg;
        logic [rob_len-1:0]  rob_idx;
        logic [xlen-1:0]     value;
    } mul_result_t;

endpackage

// ==== mul_rs.sv ====
// multiply reservation station: takes dispatches, wakes operands off the cdb, issues lowest ready
`timescale 1ns/1ps

module mul_rs
    import mul_pkg::*;
#(
    parameter int rs_size = 4  // power of two, 2..16
) (
    input  logic      clock,
    input  logic      rst,
    input  logic      flush,        // misprediction, drop everything
    input  logic      dispatch_en,
    input  dispatch_t dispatch,
    input  cdb_t      cdb,
    input  logic      mul_ready,    // multiplier can take an issue
    output logic      rs_full,
    output logic      issue_valid,
    output issue_t    issue
);

    localparam int idx_len = $clog2(rs_size);

    rs_entry_t             entries [rs_size];
    logic [rs_size-1:0]    free;       // 1 = slot empty
    logic [rs_size-1:0]    req;        // slot may issue this cycle
    logic [idx_len-1:0]    free_idx;   // where the next dispatch lands
    logic [idx_len-1:0]    pick_idx;   // slot chosen for issue
    logic                  pick_any;
    rs_entry_t             new_entry;
    logic                  opa_bypass;
    logic                  opb_bypass;

    assign rs_full = ~|free;  // every slot taken

    //////////////////////////////////////////////////
    // slot selection
    //////////////////////////////////////////////////

    // lowest free slot, scan downward so the smallest index wins
    always_comb begin
        free_idx = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (free[i]) free_idx = idx_len'(i);
        end
    end

    // occupied, both operands present, multiplier open
    always_comb begin
        for (int i = 0; i < rs_size; i++) begin
            req[i] = ~free[i] & entries[i].opa_ready & entries[i].opb_ready & mul_ready;
        end
    end

    always_comb begin
        pick_idx = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (req[i]) pick_idx = idx_len'(i);  // lowest requester
        end
    end

    assign pick_any = |req;

    //////////////////////////////////////////////////
    // dispatch packet, with same-cycle cdb bypass
    //////////////////////////////////////////////////

    assign opa_bypass = ~dispatch.opa_ready & cdb.valid & (cdb.tag == dispatch.opa_tag);
    assign opb_bypass = ~dispatch.opb_ready & cdb.valid & (cdb.tag == dispatch.opb_tag);

    always_comb begin
        new_entry.opa_ready = dispatch.opa_ready | opa_bypass;
        if (dispatch.opa_ready) begin
            new_entry.opa.value = dispatch.opa_value;
        end else if (opa_bypass) begin
            new_entry.opa.value = cdb.value;  // producer finishing right now
        end else begin
            new_entry.opa.tag_view.pad = '0;
            new_entry.opa.tag_view.tag = dispatch.opa_tag;
        end

        new_entry.opb_ready = dispatch.opb_ready | opb_bypass;
        if (dispatch.opb_ready) begin
            new_entry.opb.value = dispatch.opb_value;
        end else if (opb_bypass) begin
            new_entry.opb.value = cdb.value;
        end else begin
            new_entry.opb.tag_view.pad = '0;
            new_entry.opb.tag_view.tag = dispatch.opb_tag;
        end

        new_entry.dest_preg = dispatch.dest_preg;
        new_entry.rob_idx   = dispatch.rob_idx;
        new_entry.func      = dispatch.func;
    end

    //////////////////////////////////////////////////
    // slot state
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            free        <= '1;
            issue_valid <= 1'b0;
        end else begin
            if (dispatch_en) free[free_idx] <= 1'b0;
            if (pick_any)    free[pick_idx] <= 1'b1;  // never the dispatch slot
            if (mul_ready) issue_valid <= pick_any;   // else hold the pending issue
        end
    end

    // payload: dispatch fills an empty slot, wakeup only touches occupied ones
    always_ff @(posedge clock) begin
        if (dispatch_en) entries[free_idx] <= new_entry;
        for (int i = 0; i < rs_size; i++) begin
            if (!free[i] && cdb.valid) begin
                if (!entries[i].opa_ready && entries[i].opa.tag_view.tag == cdb.tag) begin
                    entries[i].opa_ready <= 1'b1;
                    entries[i].opa.value <= cdb.value;
                end
                if (!entries[i].opb_ready && entries[i].opb.tag_view.tag == cdb.tag) begin
                    entries[i].opb_ready <= 1'b1;
                    entries[i].opb.value <= cdb.value;
                end
            end
        end
    end

    // issue register, read through the value view
    always_ff @(posedge clock) begin
        if (pick_any) begin
            issue.opa_value <= entries[pick_idx].opa.value;
            issue.opb_value <= entries[pick_idx].opb.value;
            issue.dest_preg <= entries[pick_idx].dest_preg;
            issue.rob_idx   <= entries[pick_idx].rob_idx;
            issue.func      <= entries[pick_idx].func;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // sender must watch rs_full
    a_no_dispatch_full: assert property (
        @(posedge clock) disable iff (rst || flush) dispatch_en |-> !rs_full);

    // a blocked multiplier gets no new issue, the pending one stays put
    a_hold_when_busy: assert property (
        @(posedge clock) disable iff (rst || flush)
        !mul_ready |=> $stable(issue_valid) && (!issue_valid || $stable(issue)));

    // a freshly issued packet came from an occupied slot with both operands in
    a_issue_ready: assert property (
        @(posedge clock) disable iff (rst || flush)
        mul_ready |=> !issue_valid ||
            $past(!free[pick_idx] && entries[pick_idx].opa_ready && entries[pick_idx].opb_ready));

endmodule

// ==== mul_unit.sv ====
// multiply path top: reservation station feeding the pipelined multiplier
`timescale 1ns/1ps

module mul_unit
    import mul_pkg::*;
#(
    parameter int rs_size = 4  // station depth
) (
    input  logic        clock,
    input  logic        rst,
    input  logic        flush,         // misprediction
    input  logic        dispatch_en,
    input  dispatch_t   dispatch,
    input  cdb_t        cdb,           // wakeup broadcast
    input  logic        cdb_grant,
    output logic        rs_full,
    output logic        result_valid,
    output mul_result_t result
);

    logic   issue_valid;
    issue_t issue;
    logic   mul_ready;  // back-pressure from the pipe

    mul_rs #(
        .rs_size(rs_size)
    ) rs_i (
        .clock       (clock),
        .rst         (rst),
        .flush       (flush),
        .dispatch_en (dispatch_en),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .mul_ready   (mul_ready),
        .rs_full     (rs_full),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    mul_pipe pipe_i (
        .clock        (clock),
        .rst          (rst),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .cdb_grant    (cdb_grant),
        .mul_ready    (mul_ready),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mul_unit -f flist.f -o tb_mul_unit

./obj_dir/tb_mul_unit | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// ==== tb_mul_unit.sv ====
// testbench for the multiply path: drives mul_unit through arithmetic, wakeup, fill, stall, flush, reset
`timescale 1ns/1ps

module tb_mul_unit
    import mul_pkg::*;
();

    localparam int test_len_sum = 56 + 2 + 4 + 4 + 8 + 3;  // dispatches per test, summed

    logic        clock, rst, flush, dispatch_en, cdb_grant;
    dispatch_t   dispatch;
    cdb_t        cdb;
    logic        rs_full, result_valid;
    mul_result_t result;

    logic [31:0] pending, waiting;    // per rob: outstanding, still missing its operand
    logic [31:0] exp_val [32];        // model result per rob
    logic [5:0]  exp_dest [32];       // destination register handed over at dispatch
    logic [5:0]  wait_tag [32];
    logic [31:0] tag_val [64];        // value the tb will broadcast for each tag
    logic [4:0]  retired [$];         // rob order as results leave
    logic [4:0]  next_rob, rob_tmp;
    logic [4:0]  robs [4];
    int          errors, errors_base, passes, fails, base;
    int unsigned seed_dummy;

    mul_unit #(.rs_size(4)) dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // rv32m definition: extend per func, multiply, pick the word
    function automatic logic [31:0] rv32_mul(input mul_func_t f, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [63:0] a64, b64, p;
        a64 = (f == MULH || f == MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
        b64 = (f == MULH) ? {{32{b[31]}}, b} : {32'd0, b};
        p = a64 * b64;  // low 64 bits exact
        return (f == MUL) ? p[31:0] : p[63:32];
    endfunction

    //////////////////////////////////////////////////
    // model, follows the dut inputs edge by edge
    //////////////////////////////////////////////////

    always @(posedge clock) begin
        if (rst || flush) begin
            pending <= '0;  // everything in flight is gone
            waiting <= '0;
        end else begin
            if (result_valid && cdb_grant) begin
                pending[result.rob_idx] <= 1'b0;
                retired.push_back(result.rob_idx);
            end
            if (cdb.valid) begin
                for (int r = 0; r < 32; r++) begin
                    if (waiting[r] && wait_tag[r] == cdb.tag) waiting[r] <= 1'b0;
                end
            end
            if (dispatch_en) begin
                pending[dispatch.rob_idx]  <= 1'b1;
                waiting[dispatch.rob_idx]  <= !dispatch.opa_ready &&
                    !(cdb.valid && cdb.tag == dispatch.opa_tag);  // bypass counts as woken
                wait_tag[dispatch.rob_idx] <= dispatch.opa_tag;
                exp_dest[dispatch.rob_idx] <= dispatch.dest_preg;
                exp_val[dispatch.rob_idx]  <= rv32_mul(dispatch.func,
                    dispatch.opa_ready ? dispatch.opa_value : tag_val[dispatch.opa_tag],
                    dispatch.opb_value);
            end
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    a_known: assert property (@(posedge clock) disable iff (rst || flush)
        result_valid |-> pending[result.rob_idx])
        else begin
            errors++;
            $display("%0t: result for rob %0d which is not outstanding", $time, result.rob_idx);
        end

    a_value: assert property (@(posedge clock) disable iff (rst || flush)
        result_valid && pending[result.rob_idx] |-> result.value == exp_val[result.rob_idx])
        else begin
            errors++;
            $display("Mismatch at %0t: rob %0d value %h, expected %h", $time,
                     result.rob_idx, result.value, exp_val[result.rob_idx]);
        end

    a_dest: assert property (@(posedge clock) disable iff (rst || flush)
        result_valid && pending[result.rob_idx] |->
            result.dest_preg == exp_dest[result.rob_idx])
        else begin
            errors++;
            $display("Mismatch at %0t: rob %0d dest %0d, expected %0d", $time,
                     result.rob_idx, result.dest_preg, exp_dest[result.rob_idx]);
        end

    a_woken: assert property (@(posedge clock) disable iff (rst || flush)
        result_valid |-> !waiting[result.rob_idx])
        else begin
            errors++;
            $display("%0t: rob %0d finished before its tag was broadcast", $time, result.rob_idx);
        end

    a_stable: assert property (@(posedge clock) disable iff (rst || flush)
        result_valid && !cdb_grant |=> result_valid && $stable(result))
        else begin
            errors++;
            $display("%0t: waiting result dropped or changed without a grant", $time);
        end

    a_reset_low: assert property (@(posedge clock) rst |=> !result_valid && !rs_full)
        else begin
            errors++;
            $display("%0t: result_valid or rs_full high across reset", $time);
        end

    a_flush_low: assert property (@(posedge clock) disable iff (rst)
        flush |=> !result_valid && !rs_full)
        else begin
            errors++;
            $display("%0t: result_valid or rs_full high after flush", $time);
        end

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    task automatic report_problem(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    function automatic dispatch_t make_op(input mul_func_t f, input logic a_ready,
                                          input logic [31:0] a, input logic [5:0] a_tag,
                                          input logic [31:0] b, input logic [4:0] rob);
        dispatch_t d;
        d = '0;
        d.opa_ready = a_ready;
        d.opa_value = a;
        d.opa_tag   = a_tag;
        d.opb_ready = 1'b1;  // b always comes ready
        d.opb_value = b;
        d.dest_preg = {1'b1, rob};
        d.rob_idx   = rob;
        d.func      = f;
        return d;
    endfunction

    // one clock of inputs, set on the rising edge
    task automatic step(input logic de, input dispatch_t d, input logic cv, input logic [5:0] ct);
        @(posedge clock);
        dispatch_en <= de;
        dispatch    <= d;
        cdb.valid   <= cv;
        cdb.tag     <= ct;
        cdb.value   <= tag_val[ct];
    endtask

    task automatic send(input dispatch_t d);
        @(negedge clock);
        while (rs_full) @(negedge clock);  // never dispatch into a full station
        step(1'b1, d, 1'b0, '0);
        step(1'b0, d, 1'b0, '0);
    endtask

    task automatic dispatch_op(input mul_func_t f, input logic a_ready, input logic [31:0] a,
                               input logic [5:0] a_tag, input logic [31:0] b,
                               output logic [4:0] rob);
        rob = next_rob;
        next_rob = next_rob + 5'd1;
        send(make_op(f, a_ready, a, a_tag, b, rob));
    endtask

    task automatic broadcast(input logic [5:0] tag);
        step(1'b0, '0, 1'b1, tag);
        step(1'b0, '0, 1'b0, '0);
    endtask

    task automatic wait_drain(input int limit, input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (pending != 0 && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (pending != 0) report_problem({what, ": results still missing"});
    endtask

    task automatic wait_result(input int limit);
        int n;
        n = 0;
        @(negedge clock);
        while (!result_valid && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (!result_valid) report_problem("no result appeared");
    endtask

    task automatic close_test(input string name);
        if (errors > errors_base) begin
            fails++;
            $display("test %s: FAIL", name);
        end else begin
            passes++;
            $display("test %s: ok", name);
        end
        errors_base = errors;
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] corner [3];
        int n;
        seed_dummy  = $urandom(32'h623e);
        rst         = 1'b1;
        flush       = 1'b0;
        dispatch_en = 1'b0;
        dispatch    = '0;
        cdb         = '0;
        cdb_grant   = 1'b1;
        next_rob    = '0;
        errors      = 0;
        errors_base = 0;
        passes      = 0;
        fails       = 0;
        for (int t = 0; t < 64; t++) tag_val[t] = 32'(t) * 32'h9e3779b9;
        corner[0] = 32'h8000_0000;
        corner[1] = 32'hffff_ffff;
        corner[2] = 32'h0000_0000;
        repeat (4) @(posedge clock);
        rst <= 1'b0;

        // corners for every func, then random
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 3; j++) begin
                    dispatch_op(mul_func_t'(2'(f)), 1'b1, corner[i], '0, corner[j], rob_tmp);
                end
            end
        end
        for (int i = 0; i < 20; i++) begin
            dispatch_op(mul_func_t'(2'($urandom_range(3, 0))), 1'b1, $urandom, '0, $urandom,
                        rob_tmp);
        end
        wait_drain(40, "arithmetic");
        close_test("arithmetic");

        // tag arrives long after dispatch
        tag_val[10] = $urandom;
        dispatch_op(MULH, 1'b0, '0, 6'd10, $urandom, rob_tmp);
        repeat (8) @(posedge clock);
        broadcast(6'd10);
        wait_drain(40, "wakeup");
        // tag broadcast in the dispatch cycle itself
        @(negedge clock);
        rob_tmp = next_rob;
        next_rob = next_rob + 5'd1;
        tag_val[11] = $urandom;
        step(1'b1, make_op(MULHSU, 1'b0, '0, 6'd11, $urandom, rob_tmp), 1'b1, 6'd11);
        step(1'b0, '0, 1'b0, '0);
        wait_drain(40, "bypass");
        close_test("wakeup");

        // four entries on one tag, all wake together
        base = retired.size();
        tag_val[20] = $urandom;
        for (int k = 0; k < 4; k++) begin
            dispatch_op(mul_func_t'(2'($urandom_range(3, 0))), 1'b0, '0, 6'd20, $urandom,
                        robs[k]);
            @(negedge clock);
            if (rs_full != (k == 3)) report_problem("rs_full wrong while filling the station");
        end
        broadcast(6'd20);
        n = 0;
        while (rs_full && n < 20) begin
            @(negedge clock);
            n++;
        end
        if (rs_full) report_problem("rs_full stuck after wakeup");
        wait_drain(40, "fill");
        for (int k = 0; k < 4; k++) begin
            if (retired.size() <= base + k || retired[base + k] != robs[k]) begin
                errors++;
                $display("Mismatch at %0t: result %0d out of slot order, expected rob %0d",
                         $time, k, robs[k]);
            end
        end
        close_test("full and ordering");

        // products pile up behind a missing grant
        @(posedge clock);
        cdb_grant <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            dispatch_op(mul_func_t'(2'(i)), 1'b1, $urandom, '0, $urandom, rob_tmp);
        end
        wait_result(40);
        repeat (10) @(posedge clock);
        cdb_grant <= 1'b1;
        wait_drain(40, "back-pressure");
        close_test("back-pressure");

        // flush with products in flight and entries waiting
        @(posedge clock);
        cdb_grant <= 1'b0;
        dispatch_op(MUL, 1'b1, $urandom, '0, $urandom, rob_tmp);
        dispatch_op(MULHU, 1'b1, $urandom, '0, $urandom, rob_tmp);
        tag_val[30] = $urandom;  // never broadcast
        dispatch_op(MUL, 1'b0, '0, 6'd30, $urandom, rob_tmp);
        dispatch_op(MULH, 1'b0, '0, 6'd30, $urandom, rob_tmp);
        wait_result(40);
        @(posedge clock);
        flush <= 1'b1;
        @(posedge clock);
        flush     <= 1'b0;
        cdb_grant <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            dispatch_op(mul_func_t'(2'($urandom_range(3, 0))), 1'b1, $urandom, '0, $urandom,
                        rob_tmp);
        end
        wait_drain(40, "flush");
        close_test("flush");

        // reset in the middle of work, then one more product
        dispatch_op(MULH, 1'b1, $urandom, '0, $urandom, rob_tmp);
        dispatch_op(MUL, 1'b1, $urandom, '0, $urandom, rob_tmp);
        @(posedge clock);
        rst <= 1'b1;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        dispatch_op(MULHSU, 1'b1, $urandom, '0, $urandom, rob_tmp);
        wait_drain(40, "reset");
        close_test("reset");

        $display("%0d passed, %0d failed", passes, fails);
        if (fails == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog, twenty cycles per dispatch in all tests
    initial begin
        repeat (test_len_sum * 20) @(posedge clock);
        $display("watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

endmodule
